//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       ?= tb_keyboard_bus
FILELIST  ?= keyboard_bus_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_keyboard_bus.sv
`timescale 1ns/100ps

module tb_keyboard_bus;

    localparam int fifo_depth = 8;
    // Half a PS/2 bit in system clocks, bit period 10
    localparam int ps2_half = 5;
    // 11 bits plus the idle gap after the stop bit
    localparam int frame_cycles = 11 * 2 * ps2_half + 12;
    localparam int max_tests = 64;

    // Table operation kinds
    localparam int op_ram = 0;
    localparam int op_read = 1;
    localparam int op_uart = 2;
    localparam int op_frame = 3;
    localparam int op_key = 4;
    localparam int op_irq = 5;

    logic CLOCK_50 = 1'b0;
    logic rst_n, ps2_clk, ps2_dat, bus_write_enable, bus_read_enable, uart_strobe;
    logic [63:0] bus_address, bus_write_data, bus_read_data;
    logic [3:0]  interrupt_vector;
    logic [7:0]  uart_data;

    // Stimulus table, one row per test
    string       t_name [max_tests];
    int          t_kind [max_tests];
    logic [63:0] t_addr [max_tests];
    logic [63:0] t_data [max_tests];
    logic [63:0] t_exp [max_tests];
    int          n_tests = 0;
    bit          table_ready = 1'b0;
    int          test_errs, n_pass, n_fail;

    keyboard_bus_top #(
        .FIFO_DEPTH (fifo_depth),
        .RAM_WORDS  (1024)
    ) DUT (.*);

    // 40 ns clock
    always #20 CLOCK_50 = ~CLOCK_50;

    // Register image as the key layout defines it
    function automatic logic [63:0] key_word_of(input logic [7:0] code, input logic released,
                                                input logic valid, input logic ovf);
        logic [63:0] w;
        w = '0;
        w[keyboard_bus_pkg::key_code_lsb +: 8]       = code;
        w[keyboard_bus_pkg::key_released_bit] = released;
        w[keyboard_bus_pkg::key_valid_bit]    = valid;
        w[keyboard_bus_pkg::key_overflow_bit] = ovf;
        return w;
    endfunction

    task automatic add_test(input string name, input int kind, input logic [63:0] addr,
                            input logic [63:0] data, input logic [63:0] exp);
        t_name[n_tests] = name;
        t_kind[n_tests] = kind;
        t_addr[n_tests] = addr;
        t_data[n_tests] = data;
        t_exp[n_tests]  = exp;
        n_tests++;
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp) else begin
            $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, got);
            test_errs++;
        end
    endtask

    // Write lands on the edge that samples the enable
    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
        @(negedge CLOCK_50);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
    endtask

    // Data sampled one cycle after the read strobe
    task automatic bus_read(input logic [63:0] addr, output logic [63:0] data);
        @(negedge CLOCK_50);
        bus_address     = addr;
        bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        data = bus_read_data;
    endtask

    // Device side of a PS/2 frame, data changes while the clock is high
    task automatic ps2_send(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        // Odd parity, flipped on request
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int b = 0; b < 11; b++) begin
            @(negedge CLOCK_50);
            ps2_dat = frame[b];
            repeat (ps2_half - 1) @(negedge CLOCK_50);
            ps2_clk = 1'b0;
            repeat (ps2_half) @(negedge CLOCK_50);
            ps2_clk = 1'b1;
        end
        @(negedge CLOCK_50);
        ps2_dat = 1'b1;
        repeat (11) @(negedge CLOCK_50);
    endtask

    // Poll the level interrupt, bounded
    // Zero limit samples at once
    task automatic wait_irq(input string name, input logic [3:0] exp, input int limit);
        int cycles;
        cycles = 0;
        while (interrupt_vector !== exp && cycles < limit) begin
            @(negedge CLOCK_50);
            cycles++;
        end
        check_value(name, 64'(exp), 64'(interrupt_vector));
        // No UART write pending here
        check_value(name, 64'd0, 64'(uart_strobe));
    endtask

    task automatic build_table();
        logic [63:0] rnd;
        logic [63:0] ram_words [4];
        // Interrupt rows carry the poll limit in the data column
        add_test("reset_irq", op_irq, '0, '0, '0);
        add_test("reset_key", op_key, keyboard_bus_pkg::key_addr, '0, '0);
        for (int k = 0; k < 4; k++) begin
            rnd = {$urandom, $urandom};
            ram_words[k] = rnd;
            add_test($sformatf("ram_%0d", k), op_ram, keyboard_bus_pkg::ram_base + 64'(k * 'h7f8),
                     rnd, rnd);
        end
        rnd = {$urandom, $urandom};
        add_test("ram_last", op_ram, 64'h2ff8, rnd, rnd);
        // Earlier words survive the later writes
        for (int k = 0; k < 4; k++) begin
            add_test($sformatf("ram_%0d_again", k), op_read,
                     keyboard_bus_pkg::ram_base + 64'(k * 'h7f8), '0, ram_words[k]);
        end
        add_test("unmapped_read", op_read, 64'h4000, '0, '0);
        add_test("past_ram_read", op_read, 64'h3000, '0, '0);
        add_test("uart_read", op_read, keyboard_bus_pkg::uart_addr, '0, '0);
        // Make, then break of the same key
        add_test("make_1c", op_frame, '0, 64'h1c, '0);
        add_test("break_f0", op_frame, '0, 64'(keyboard_bus_pkg::break_code), '0);
        add_test("break_1c", op_frame, '0, 64'h1c, '0);
        add_test("irq_set", op_irq, '0, 64'd20, 64'd1);
        add_test("key_make", op_key, keyboard_bus_pkg::key_addr, '0, key_word_of(8'h1c, 0, 1, 0));
        add_test("irq_held", op_irq, '0, 64'd20, 64'd1);
        add_test("key_break", op_key, keyboard_bus_pkg::key_addr, '0, key_word_of(8'h1c, 1, 1, 0));
        add_test("irq_clear", op_irq, '0, 64'd20, '0);
        // Bit 8 of the data asks for a parity error
        add_test("bad_parity", op_frame, '0, 64'h12a, '0);
        add_test("bad_parity_key", op_key, keyboard_bus_pkg::key_addr, '0, '0);
        for (int k = 0; k < fifo_depth + 2; k++) begin
            add_test($sformatf("ovf_send_%0d", k), op_frame, '0, 64'(8'h10 + k), '0);
        end
        for (int k = 0; k < fifo_depth; k++) begin
            add_test($sformatf("ovf_key_%0d", k), op_key, keyboard_bus_pkg::key_addr, '0,
                     key_word_of(8'(8'h10 + k), 0, 1, k == 0));
        end
        add_test("ovf_empty", op_key, keyboard_bus_pkg::key_addr, '0, '0);
        add_test("ovf_irq", op_irq, '0, 64'd20, '0);
        add_test("uart_write", op_uart, keyboard_bus_pkg::uart_addr, 64'h0123_4567_89ab_cda5,
                 64'ha5);
    endtask

    initial begin
        logic [63:0] got;
        void'($urandom(1));
        rst_n            = 1'b0;
        ps2_clk          = 1'b1;
        ps2_dat          = 1'b1;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        n_pass           = 0;
        n_fail           = 0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(negedge CLOCK_50);
        rst_n = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            test_errs = 0;
            case (t_kind[i])
                op_ram: begin
                    bus_write(t_addr[i], t_data[i]);
                    bus_read(t_addr[i], got);
                    check_value(t_name[i], t_exp[i], got);
                end
                op_read, op_key: begin
                    bus_read(t_addr[i], got);
                    check_value(t_name[i], t_exp[i], got);
                end
                op_uart: begin
                    bus_write(t_addr[i], t_data[i]);
                    check_value(t_name[i], 64'd1, 64'(uart_strobe));
                    check_value(t_name[i], t_exp[i], 64'(uart_data));
                    // Exactly one pulse
                    repeat (2) begin
                        @(negedge CLOCK_50);
                        check_value(t_name[i], 64'd0, 64'(uart_strobe));
                    end
                end
                op_frame: ps2_send(t_data[i][7:0], t_data[i][8]);
                default: wait_irq(t_name[i], t_exp[i][3:0], int'(t_data[i]));
            endcase
            if (test_errs == 0) begin
                n_pass++;
                $display("test %s passed", t_name[i]);
            end else begin
                n_fail++;
                $display("test %s failed", t_name[i]);
            end
        end
        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Twice the time of one frame per table row
    initial begin
        wait (table_ready);
        #(n_tests * frame_cycles * 40 * 2);
        $display("timeout, the test table did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- keyboard_bus_top.f
logic/keyboard_bus_pkg.sv
logic/key_event_if.sv
logic/ps2_receiver.sv
logic/scan_fifo.sv
logic/key_port.sv
logic/memory_map.sv
logic/keyboard_bus_top.sv
dv/tb_keyboard_bus.sv

//--- logic/key_event_if.sv
`timescale 1ns/100ps

interface key_event_if;

    // Oldest event in the buffer
    keyboard_bus_pkg::key_event_t head;
    logic                         not_empty;
    logic                         overflow;
    // Pulses from the keyboard port
    logic                         pop;
    logic                         clear_overflow;

    // Buffer side
    modport buffer (
        output head,
        output not_empty,
        output overflow,
        input  pop,
        input  clear_overflow
    );

    // Keyboard port side
    modport port (
        input  head,
        input  not_empty,
        input  overflow,
        output pop,
        output clear_overflow
    );

endinterface

//--- logic/key_port.sv
`timescale 1ns/100ps

module key_port (
    input  logic                                    CLOCK_50,
    input  logic                                    rst_n,
    input  logic                                    key_read,
    output logic [keyboard_bus_pkg::bus_data_w-1:0] key_word,
    output logic [3:0]                              interrupt_vector,
    key_event_if.port                               events
);

    logic [keyboard_bus_pkg::bus_data_w-1:0] word_next;

    // Register image, unused bits stay zero
    always_comb begin
        word_next = '0;
        if (events.not_empty) begin
            word_next[keyboard_bus_pkg::key_code_lsb +: keyboard_bus_pkg::key_code_w] =
                events.head.code;
            word_next[keyboard_bus_pkg::key_released_bit] = events.head.released;
            word_next[keyboard_bus_pkg::key_valid_bit]    = 1'b1;
        end
        // Overflow shows even with nothing left to return
        word_next[keyboard_bus_pkg::key_overflow_bit] = events.overflow;
    end

    // Read pops the head and clears the sticky flag
    assign events.pop            = key_read & events.not_empty;
    assign events.clear_overflow = key_read;

    // Read data, held until the next keyboard read
    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            key_word <= '0;
        end else if (key_read) begin
            key_word <= word_next;
        end
    end

    // Level interrupt on line 0, high while events wait
    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            interrupt_vector <= 4'd0;
        end else begin
            interrupt_vector <= {3'b000, events.not_empty};
        end
    end

endmodule

//--- logic/keyboard_bus_pkg.sv
package keyboard_bus_pkg;

    // Bus widths of the 64-bit CPU port
    localparam int bus_addr_w = 64;
    localparam int bus_data_w = 64;

    // RAM window, stack folded in
    localparam logic [bus_addr_w-1:0] ram_base = 64'h0000_0000_0000_1000;
    // 8 KB
    localparam logic [bus_addr_w-1:0] ram_size = 64'h0000_0000_0000_2000;

    // UART transmit register, qemu style location
    localparam logic [bus_addr_w-1:0] uart_addr = 64'h0000_0000_8000_0000;
    // Keyboard register
    localparam logic [bus_addr_w-1:0] key_addr = 64'h0000_0000_8000_0010;

    // PS/2 set 2 prefix bytes
    localparam logic [7:0] break_code = 8'hF0;
    // Extended prefix, dropped here
    localparam logic [7:0] ext_code = 8'hE0;

    // Width of one scan code
    localparam int key_code_w = 8;

    // One buffered key event
    typedef struct packed {
        logic [key_code_w-1:0] code;
        logic                  released;
    } key_event_t;

    // Keyboard register fields
    // Scan code in the low byte
    localparam int key_code_lsb = 0;
    // Set for a break event
    localparam int key_released_bit = 8;
    // Set when the read returned an event
    localparam int key_valid_bit = 9;
    // Sticky overflow, cleared by the read that shows it
    localparam int key_overflow_bit = 10;

endpackage

//--- logic/keyboard_bus_top.sv
`timescale 1ns/100ps

module keyboard_bus_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int RAM_WORDS  = 1024
) (
    input  logic                                    CLOCK_50,
    input  logic                                    rst_n,
    // PS/2 pins
    input  logic                                    ps2_clk,
    input  logic                                    ps2_dat,
    // CPU bus
    input  logic [keyboard_bus_pkg::bus_addr_w-1:0] bus_address,
    input  logic [keyboard_bus_pkg::bus_data_w-1:0] bus_write_data,
    input  logic                                    bus_write_enable,
    input  logic                                    bus_read_enable,
    output logic [keyboard_bus_pkg::bus_data_w-1:0] bus_read_data,
    // Interrupt lines to the CPU
    output logic [3:0]                              interrupt_vector,
    // Toward the UART core
    output logic [7:0]                              uart_data,
    output logic                                    uart_strobe
);

    // Receiver to buffer
    logic                         code_strobe;
    keyboard_bus_pkg::key_event_t key_event;

    // Memory map to keyboard port
    logic                                    key_read;
    logic [keyboard_bus_pkg::bus_data_w-1:0] key_word;

    // Buffer to keyboard port
    key_event_if key_bus ();

    ps2_receiver u_ps2_receiver (
        .CLOCK_50    (CLOCK_50),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .code_strobe (code_strobe),
        .key_event   (key_event)
    );

    scan_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_scan_fifo (
        .CLOCK_50    (CLOCK_50),
        .rst_n       (rst_n),
        .code_strobe (code_strobe),
        .key_event   (key_event),
        .out         (key_bus)
    );

    key_port u_key_port (
        .CLOCK_50         (CLOCK_50),
        .rst_n            (rst_n),
        .key_read         (key_read),
        .key_word         (key_word),
        .interrupt_vector (interrupt_vector),
        .events           (key_bus)
    );

    memory_map #(
        .RAM_WORDS (RAM_WORDS)
    ) u_memory_map (
        .CLOCK_50         (CLOCK_50),
        .rst_n            (rst_n),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_read         (key_read),
        .key_word         (key_word),
        .uart_data        (uart_data),
        .uart_strobe      (uart_strobe)
    );

endmodule

//--- logic/memory_map.sv
`timescale 1ns/100ps

module memory_map #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                                    CLOCK_50,
    input  logic                                    rst_n,
    input  logic [keyboard_bus_pkg::bus_addr_w-1:0] bus_address,
    input  logic [keyboard_bus_pkg::bus_data_w-1:0] bus_write_data,
    input  logic                                    bus_write_enable,
    input  logic                                    bus_read_enable,
    output logic [keyboard_bus_pkg::bus_data_w-1:0] bus_read_data,
    output logic                                    key_read,
    input  logic [keyboard_bus_pkg::bus_data_w-1:0] key_word,
    output logic [7:0]                              uart_data,
    output logic                                    uart_strobe
);

    localparam int addr_w  = keyboard_bus_pkg::bus_addr_w;
    localparam int data_w  = keyboard_bus_pkg::bus_data_w;
    localparam int index_w = $clog2(RAM_WORDS);

    // Source of the registered read data
    typedef enum logic [1:0] {
        src_zero,
        src_ram,
        src_key
    } read_src_t;

    logic [data_w-1:0]  ram [RAM_WORDS];
    logic [data_w-1:0]  ram_q;
    logic [addr_w-1:0]  ram_offset;
    logic [index_w-1:0] ram_index;
    logic               ram_sel;
    logic               uart_sel;
    logic               key_sel;
    read_src_t          read_src;

    // Address decode
    assign ram_offset = bus_address - keyboard_bus_pkg::ram_base;
    // Also bounded by the words actually built
    assign ram_sel = (bus_address >= keyboard_bus_pkg::ram_base) &&
                     (ram_offset < keyboard_bus_pkg::ram_size) &&
                     ((ram_offset >> 3) < addr_w'(RAM_WORDS));
    assign uart_sel = (bus_address == keyboard_bus_pkg::uart_addr);
    assign key_sel  = (bus_address == keyboard_bus_pkg::key_addr);

    // 64-bit words, byte lane bits ignored
    assign ram_index = ram_offset[index_w+2:3];

    // Keyboard read strobe, answered next cycle
    assign key_read = bus_read_enable & key_sel;

    // RAM, read-before-write on a shared address
    always_ff @(posedge CLOCK_50) begin
        if (bus_write_enable && ram_sel) begin
            ram[ram_index] <= bus_write_data;
        end
        if (bus_read_enable && ram_sel) begin
            ram_q <= ram[ram_index];
        end
    end

    // UART byte, strobe one cycle after the write
    always_ff @(posedge CLOCK_50) begin
        if (bus_write_enable && uart_sel) begin
            uart_data <= bus_write_data[7:0];
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            uart_strobe <= 1'b0;
        end else begin
            uart_strobe <= bus_write_enable & uart_sel;
        end
    end

    // Remember what the last read hit, UART and unmapped read zero
    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            read_src <= src_zero;
        end else if (bus_read_enable) begin
            if (ram_sel) begin
                read_src <= src_ram;
            end else if (key_sel) begin
                read_src <= src_key;
            end else begin
                read_src <= src_zero;
            end
        end
    end

    // Both sources are registers, so data holds until the next read
    always_comb begin
        case (read_src)
            src_ram: bus_read_data = ram_q;
            src_key: bus_read_data = key_word;
            default: bus_read_data = '0;
        endcase
    end

endmodule

//--- logic/ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver (
    input  logic                         CLOCK_50,
    input  logic                         rst_n,
    input  logic                         ps2_clk,
    input  logic                         ps2_dat,
    output logic                         code_strobe,
    output keyboard_bus_pkg::key_event_t key_event
);

    // Mid-frame silence this long means a lost bit, so start over
    localparam logic [15:0] idle_limit = 16'hFFFF;

    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        clk_fall;
    logic [3:0]  bit_count;
    logic [9:0]  shift_reg;
    logic [15:0] idle_count;
    logic        release_pending;
    logic [7:0]  frame_byte;
    logic        frame_ok;
    logic        stop_bit;

    // Two-stage synchronizers, lines idle high
    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // Device changes data on rising edge, sample on falling
    assign clk_fall = clk_prev & ~clk_sync[1];

    // Eleventh bit on the line
    assign stop_bit = clk_fall && (bit_count == 4'd10);

    // Start low, odd parity over data and parity bit, stop high
    assign frame_byte = shift_reg[8:1];
    assign frame_ok   = ~shift_reg[0] & (^shift_reg[9:1]) & dat_sync[1];

    // Bit counter and break tracking
    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            bit_count       <= '0;
            idle_count      <= '0;
            release_pending <= 1'b0;
            code_strobe     <= 1'b0;
        end else begin
            code_strobe <= 1'b0;
            if (clk_fall) begin
                idle_count <= '0;
                if (stop_bit) begin
                    bit_count <= '0;
                    if (frame_ok) begin
                        if (frame_byte == keyboard_bus_pkg::break_code) begin
                            // Next code is a release
                            release_pending <= 1'b1;
                        end else if (frame_byte != keyboard_bus_pkg::ext_code) begin
                            code_strobe     <= 1'b1;
                            release_pending <= 1'b0;
                        end
                    end
                end else begin
                    bit_count <= bit_count + 4'd1;
                end
            end else if (bit_count != 4'd0) begin
                // Watchdog only runs inside a frame
                if (idle_count == idle_limit) begin
                    bit_count  <= '0;
                    idle_count <= '0;
                end else begin
                    idle_count <= idle_count + 16'd1;
                end
            end
        end
    end

    // Shift in LSB first, start bit ends in bit 0
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall && !stop_bit) begin
            shift_reg <= {dat_sync[1], shift_reg[9:1]};
        end
        // Event payload, qualified by code_strobe
        if (stop_bit) begin
            key_event.code     <= frame_byte;
            key_event.released <= release_pending;
        end
    end

endmodule

//--- logic/scan_fifo.sv
`timescale 1ns/100ps

module scan_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                         CLOCK_50,
    input  logic                         rst_n,
    input  logic                         code_strobe,
    input  keyboard_bus_pkg::key_event_t key_event,
    key_event_if.buffer                  out
);

    // Depth is a power of two, pointers wrap on their own
    localparam int addr_w = $clog2(FIFO_DEPTH);

    keyboard_bus_pkg::key_event_t store [FIFO_DEPTH];

    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   count;
    logic              full;
    logic              do_push;
    logic              do_pop;
    logic              overflow_flag;

    assign full = (count == (addr_w + 1)'(FIFO_DEPTH));

    // Pop on empty is a no-op
    assign do_pop  = out.pop & (count != '0);
    // Full but popping this cycle still has room
    assign do_push = code_strobe & (~full | do_pop);

    always_ff @(posedge CLOCK_50) begin
        if (do_push) begin
            store[wr_ptr] <= key_event;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            overflow_flag <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Dropped event wins over a clear in the same cycle
            if (code_strobe && !do_push) begin
                overflow_flag <= 1'b1;
            end else if (out.clear_overflow) begin
                overflow_flag <= 1'b0;
            end
        end
    end

    // Oldest entry, first-word fall-through
    assign out.head      = store[rd_ptr];
    assign out.not_empty = (count != '0);
    assign out.overflow  = overflow_flag;

endmodule
